/* hdl/opx_pkg.sv */
// Shared opcode and operand-source encodings; widths here are fixed and not tied to DATA_W

package opx_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Opcode field width on every micro-op port
	localparam int OPX_OP_W  = 3;
	// Operand source select width
	localparam int OPX_SRC_W = 2;

	//////////////////////////////////////////////////
	// ALU operations
	//////////////////////////////////////////////////

	// All eight codes are used, so any opcode is legal
	typedef enum logic [OPX_OP_W-1:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6,
		// Signed compare, result is 0 or 1
		OP_SLT = 3'd7
	} opx_op_e;

	//////////////////////////////////////////////////
	// Operand sources
	//////////////////////////////////////////////////

	// SRC_IMM only makes sense for operand B
	typedef enum logic [OPX_SRC_W-1:0] {
		SRC_RF     = 2'd0,
		SRC_IMM    = 2'd1,
		SRC_EX_FWD = 2'd2,
		SRC_WB_FWD = 2'd3
	} opx_src_e;

endpackage

/* hdl/opx_regfile.sv */
// REG_CNT must be a power of two; register 0 reads zero; a write is visible to reads next cycle
`timescale 1ns/1ps

module opx_regfile #(
	parameter int  DATA_W  = 32,
	parameter int  REG_CNT = 16,
	localparam int IDX_W   = $clog2(REG_CNT)
) (
	input  logic              clk,
	input  logic              rst_n,
	// Read port A
	input  logic [IDX_W-1:0]  rd_addr_a,
	output logic [DATA_W-1:0] rd_data_a,
	// Read port B
	input  logic [IDX_W-1:0]  rd_addr_b,
	output logic [DATA_W-1:0] rd_data_b,
	// Write port, driven by the WB output handshake
	input  logic              wr_en,
	input  logic [IDX_W-1:0]  wr_addr,
	input  logic [DATA_W-1:0] wr_data
);

	// Storage array, entry 0 never written
	logic [DATA_W-1:0] regs [REG_CNT];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// Whole file starts at zero
			for (int i = 0; i < REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Combinational reads, address 0 forced to zero
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

	// Register 0 stays zero across a write that targets it
	a_r0_write_ignored: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr_en && (wr_addr == '0)) |=> (regs[0] == '0)
	);

endmodule

/* hdl/opx_operand_mux.sv */
// Selects are trusted from the control block; sel_a must never be SRC_IMM; no split ID/EX freeze
`timescale 1ns/1ps

module opx_operand_mux import opx_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	// Global hold from output back-pressure
	input  logic              stall,
	// Candidate sources
	input  logic [DATA_W-1:0] rf_data_a,
	input  logic [DATA_W-1:0] rf_data_b,
	input  logic [DATA_W-1:0] ex_fwd,
	input  logic [DATA_W-1:0] wb_fwd,
	input  logic [DATA_W-1:0] imm,
	// Source selects from ID
	input  opx_src_e          sel_a,
	input  opx_src_e          sel_b,
	// Registered operands into EX
	output logic [DATA_W-1:0] operand_a,
	output logic [DATA_W-1:0] operand_b,
	// Pre-register mux values
	output logic [DATA_W-1:0] muxed_a,
	output logic [DATA_W-1:0] muxed_b
);

	//////////////////////////////////////////////////
	// Forwarding muxes
	//////////////////////////////////////////////////

	// Operand A, register file unless a forward applies
	always_comb begin
		case (sel_a)
			SRC_EX_FWD: muxed_a = ex_fwd;
			SRC_WB_FWD: muxed_a = wb_fwd;
			// SRC_IMM is not meaningful here
			default:    muxed_a = rf_data_a;
		endcase
	end

	// Operand B, also takes the immediate
	always_comb begin
		case (sel_b)
			SRC_IMM:    muxed_b = imm;
			SRC_EX_FWD: muxed_b = ex_fwd;
			SRC_WB_FWD: muxed_b = wb_fwd;
			default:    muxed_b = rf_data_b;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// Whole pipe freezes together, so one hold condition suffices
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
		end else if (!stall) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Control never routes the immediate to A
	a_sel_a_no_imm: assert property (
		@(posedge clk) disable iff (!rst_n)
		sel_a != SRC_IMM
	);

	// Free-running edge captures the mux
	a_capture: assert property (
		@(posedge clk) disable iff (!rst_n)
		!stall |=> (operand_a == $past(muxed_a)) && (operand_b == $past(muxed_b))
	);

	// Operands frozen with the rest of the pipe
	a_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(operand_a) && $stable(operand_b)
	);

endmodule

/* hdl/opx_pipe_ctrl.sv */
// Back-pressure freezes every stage; no hazard needs a bubble; register 0 never forwards
`timescale 1ns/1ps

module opx_pipe_ctrl import opx_pkg::*; #(
	parameter int  DATA_W  = 32,
	parameter int  REG_CNT = 16,
	localparam int IDX_W   = $clog2(REG_CNT)
) (
	input  logic                clk,
	input  logic                rst_n,
	// Input micro-op stream
	input  logic                in_valid,
	input  logic [OPX_OP_W-1:0] in_op,
	input  logic [IDX_W-1:0]    in_rd,
	input  logic [IDX_W-1:0]    in_ra,
	input  logic [IDX_W-1:0]    in_rb,
	input  logic                in_use_imm,
	input  logic [DATA_W-1:0]   in_imm,
	output logic                in_ready,
	// EX and WB status for forwarding
	input  logic                ex_valid,
	input  logic [IDX_W-1:0]    ex_rd,
	input  logic                out_valid,
	input  logic                out_ready,
	// Global hold
	output logic                stall,
	// ID stage contents
	output logic                id_valid,
	output logic [OPX_OP_W-1:0] id_op,
	output logic [IDX_W-1:0]    id_rd,
	output logic [IDX_W-1:0]    id_ra,
	output logic [IDX_W-1:0]    id_rb,
	output logic [DATA_W-1:0]   id_imm,
	// Forwarding selects
	output opx_src_e            sel_a,
	output opx_src_e            sel_b
);

	logic             in_fire;
	logic             id_use_imm;
	// Shadow of the WB destination
	logic [IDX_W-1:0] wb_rd;

	// Newest producer wins, register 0 excluded
	function automatic opx_src_e fwd_src(
		input logic [IDX_W-1:0] src,
		input logic             ex_v,
		input logic [IDX_W-1:0] ex_d,
		input logic             wb_v,
		input logic [IDX_W-1:0] wb_d
	);
		if ((src != '0) && ex_v && (src == ex_d)) return SRC_EX_FWD;
		if ((src != '0) && wb_v && (src == wb_d)) return SRC_WB_FWD;
		return SRC_RF;
	endfunction

	//////////////////////////////////////////////////
	// Flow control
	//////////////////////////////////////////////////

	// Held result at WB blocks everything behind it
	assign stall    = out_valid && !out_ready;
	assign in_ready = !stall;
	assign in_fire  = in_valid && in_ready;

	// ID register, bubble when nothing arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid   <= 1'b0;
			id_op      <= '0;
			id_rd      <= '0;
			id_ra      <= '0;
			id_rb      <= '0;
			id_use_imm <= 1'b0;
			wb_rd      <= '0;
		end else if (!stall) begin
			id_valid <= in_fire;
			// Tracks out_rd in step with the WB register
			wb_rd    <= ex_rd;
			if (in_fire) begin
				id_op      <= in_op;
				id_rd      <= in_rd;
				id_ra      <= in_ra;
				id_rb      <= in_rb;
				id_use_imm <= in_use_imm;
			end
		end
	end

	// Immediate payload
	always_ff @(posedge clk) begin
		if (in_fire) id_imm <= in_imm;
	end

	// Source selects for both operands
	always_comb begin
		sel_a = fwd_src(id_ra, ex_valid, ex_rd, out_valid, wb_rd);
		sel_b = id_use_imm ? SRC_IMM : fwd_src(id_rb, ex_valid, ex_rd, out_valid, wb_rd);
	end

	// Back-pressure refuses input and freezes ID
	a_no_accept_in_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |-> !in_ready ##1 ($stable(id_valid) && $stable(id_ra))
	);

endmodule

/* hdl/opx_alu.sv */
// Shifts use only the low log2(DATA_W) bits of B; slt is signed; WB holds while out_ready is low
`timescale 1ns/1ps

module opx_alu import opx_pkg::*; #(
	parameter int  DATA_W  = 32,
	parameter int  REG_CNT = 16,
	localparam int IDX_W   = $clog2(REG_CNT)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	// From ID
	input  logic                id_valid,
	input  logic [OPX_OP_W-1:0] id_op,
	input  logic [IDX_W-1:0]    id_rd,
	// Registered operands
	input  logic [DATA_W-1:0]   operand_a,
	input  logic [DATA_W-1:0]   operand_b,
	// EX stage status and forward value
	output logic                ex_valid,
	output logic [IDX_W-1:0]    ex_rd,
	output logic [DATA_W-1:0]   ex_fwd,
	// WB output stream
	output logic                out_valid,
	output logic [IDX_W-1:0]    out_rd,
	output logic [DATA_W-1:0]   out_data
);

	// Shift amount width
	localparam int SH_W = $clog2(DATA_W);

	opx_op_e ex_op;

	//////////////////////////////////////////////////
	// EX stage
	//////////////////////////////////////////////////

	// Operation and destination travel beside the operands
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_op    <= OP_ADD;
			ex_rd    <= '0;
		end else if (!stall) begin
			ex_valid <= id_valid;
			ex_op    <= opx_op_e'(id_op);
			ex_rd    <= id_rd;
		end
	end

	// ALU, also the EX forward value
	always_comb begin
		case (ex_op)
			OP_ADD: ex_fwd = operand_a + operand_b;
			OP_SUB: ex_fwd = operand_a - operand_b;
			OP_AND: ex_fwd = operand_a & operand_b;
			OP_OR:  ex_fwd = operand_a | operand_b;
			OP_XOR: ex_fwd = operand_a ^ operand_b;
			OP_SLL: ex_fwd = operand_a << operand_b[SH_W-1:0];
			OP_SRL: ex_fwd = operand_a >> operand_b[SH_W-1:0];
			OP_SLT: ex_fwd = {{(DATA_W-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
			default: ex_fwd = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// WB stage
	//////////////////////////////////////////////////

	// Taken result replaced by EX, or dropped if EX is empty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_rd    <= '0;
		end else if (!stall) begin
			out_valid <= ex_valid;
			out_rd    <= ex_rd;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (!stall) out_data <= ex_fwd;
	end

	// Offered result stays put until taken
	a_out_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && stall) |=> out_valid && $stable(out_data) && $stable(out_rd)
	);

endmodule

/* hdl/opx_pipe.sv */
// Three-stage ID/EX/WB integer pipe; REG_CNT a power of two; DATA_W of 16, 32 or 64
`timescale 1ns/1ps

module opx_pipe import opx_pkg::*; #(
	parameter int  DATA_W  = 32,
	parameter int  REG_CNT = 16,
	localparam int IDX_W   = $clog2(REG_CNT)
) (
	input  logic                clk,
	input  logic                rst_n,
	// Micro-op input stream
	input  logic                in_valid,
	input  logic [OPX_OP_W-1:0] in_op,
	input  logic [IDX_W-1:0]    in_rd,
	input  logic [IDX_W-1:0]    in_ra,
	input  logic [IDX_W-1:0]    in_rb,
	input  logic                in_use_imm,
	input  logic [DATA_W-1:0]   in_imm,
	output logic                in_ready,
	// Result output stream
	output logic                out_valid,
	output logic [IDX_W-1:0]    out_rd,
	output logic [DATA_W-1:0]   out_data,
	input  logic                out_ready
);

	logic                stall;
	logic                id_valid;
	logic [OPX_OP_W-1:0] id_op;
	logic [IDX_W-1:0]    id_rd;
	logic [IDX_W-1:0]    id_ra;
	logic [IDX_W-1:0]    id_rb;
	logic [DATA_W-1:0]   id_imm;
	opx_src_e            sel_a;
	opx_src_e            sel_b;
	logic [DATA_W-1:0]   rf_data_a;
	logic [DATA_W-1:0]   rf_data_b;
	logic [DATA_W-1:0]   operand_a;
	logic [DATA_W-1:0]   operand_b;
	logic                ex_valid;
	logic [IDX_W-1:0]    ex_rd;
	logic [DATA_W-1:0]   ex_fwd;
	logic                rf_wr_en;

	// Register file write on the output handshake
	assign rf_wr_en = out_valid && out_ready;

	opx_pipe_ctrl #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) i_opx_pipe_ctrl (
		.clk, .rst_n,
		.in_valid, .in_op, .in_rd, .in_ra, .in_rb, .in_use_imm, .in_imm, .in_ready,
		.ex_valid, .ex_rd, .out_valid, .out_ready,
		.stall, .id_valid, .id_op, .id_rd, .id_ra, .id_rb, .id_imm,
		.sel_a, .sel_b
	);

	opx_regfile #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) i_opx_regfile (
		.clk, .rst_n,
		.rd_addr_a (id_ra),
		.rd_data_a (rf_data_a),
		.rd_addr_b (id_rb),
		.rd_data_b (rf_data_b),
		.wr_en     (rf_wr_en),
		.wr_addr   (out_rd),
		.wr_data   (out_data)
	);

	// WB forward is the offered result itself
	opx_operand_mux #(.DATA_W(DATA_W)) i_opx_operand_mux (
		.clk, .rst_n, .stall,
		.rf_data_a, .rf_data_b, .ex_fwd,
		.wb_fwd    (out_data),
		.imm       (id_imm),
		.sel_a, .sel_b, .operand_a, .operand_b,
		// Pre-register values, observable for debug
		.muxed_a   (),
		.muxed_b   ()
	);

	opx_alu #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) i_opx_alu (
		.clk, .rst_n, .stall,
		.id_valid, .id_op, .id_rd, .operand_a, .operand_b,
		.ex_valid, .ex_rd, .ex_fwd,
		.out_valid, .out_rd, .out_data
	);

endmodule

/* tb/opx_pipe_tb.sv */
// Stim file assumes DATA_W 32 and REG_CNT 16; run from the project root so tb/ paths resolve
`timescale 1ns/1ps

module opx_pipe_tb import opx_pkg::*; ();

	localparam int DATA_W   = 32;
	localparam int REG_CNT  = 16;
	localparam int IDX_W    = $clog2(REG_CNT);
	localparam int MAX_OPS  = 256;
	localparam int CLK_HALF = 10;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	logic [OPX_OP_W-1:0] in_op;
	logic [IDX_W-1:0]    in_rd;
	logic [IDX_W-1:0]    in_ra;
	logic [IDX_W-1:0]    in_rb;
	logic                in_use_imm;
	logic [DATA_W-1:0]   in_imm;
	logic                in_ready;
	logic                out_valid;
	logic [IDX_W-1:0]    out_rd;
	logic [DATA_W-1:0]   out_data;
	logic                out_ready;

	// Micro-op table with expected results
	logic [OPX_OP_W-1:0] stim_op   [MAX_OPS];
	logic [IDX_W-1:0]    stim_rd   [MAX_OPS];
	logic [IDX_W-1:0]    stim_ra   [MAX_OPS];
	logic [IDX_W-1:0]    stim_rb   [MAX_OPS];
	logic                stim_uimm [MAX_OPS];
	logic [DATA_W-1:0]   stim_imm  [MAX_OPS];
	logic [DATA_W-1:0]   stim_exp  [MAX_OPS];
	int                  n_ops;
	logic                loaded;

	// Stream bookkeeping
	int                  in_idx;
	int                  out_idx;
	logic                in_fire;
	logic                held;
	logic [IDX_W-1:0]    held_rd;
	logic [DATA_W-1:0]   held_data;
	logic [16:0]         lfsr_state;

	opx_pipe #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) i_opx_pipe (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// 17-bit Fibonacci LFSR with taps 17 and 14
	function automatic logic [16:0] lfsr_next(input logic [16:0] state);
		logic feedback;
		feedback = state[16] ^ state[13];
		return {state[15:0], feedback};
	endfunction

	// One step per bit taken
	task automatic draw_bit(output logic value);
		lfsr_state = lfsr_next(lfsr_state);
		value      = lfsr_state[0];
	endtask

	task automatic compare_values(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "value check failed");
		end
	endtask

	// Hash lines are comments
	task automatic load_stim();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] f_op, f_rd, f_ra, f_rb, f_uimm, f_imm, f_exp;
		n_ops = 0;
		fd    = $fopen("tb/opx_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/opx_stim.txt");
			$display("test failed");
			$fatal(1, "stim file missing");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == 8'h23) continue;
			cnt = $sscanf(line, "%h %h %h %h %h %h %h",
				f_op, f_rd, f_ra, f_rb, f_uimm, f_imm, f_exp);
			if (cnt == 7 && n_ops < MAX_OPS) begin
				stim_op[n_ops]   = f_op[OPX_OP_W-1:0];
				stim_rd[n_ops]   = f_rd[IDX_W-1:0];
				stim_ra[n_ops]   = f_ra[IDX_W-1:0];
				stim_rb[n_ops]   = f_rb[IDX_W-1:0];
				stim_uimm[n_ops] = f_uimm[0];
				stim_imm[n_ops]  = f_imm;
				stim_exp[n_ops]  = f_exp;
				n_ops++;
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Per-cycle drive and check
	//////////////////////////////////////////////////

	// Drive on the falling edge and sample 1 ns later once everything has settled
	task automatic run_cycle();
		logic gap_a;
		logic gap_b;
		logic rdy;
		@(negedge clk);
		// Offered micro-op stays until taken
		if (!(in_valid && !in_fire)) begin
			in_valid = 1'b0;
			if (in_idx < n_ops) begin
				draw_bit(gap_a);
				draw_bit(gap_b);
				// Roughly one gap in four
				if (!(gap_a && gap_b)) begin
					in_valid   = 1'b1;
					in_op      = stim_op[in_idx];
					in_rd      = stim_rd[in_idx];
					in_ra      = stim_ra[in_idx];
					in_rb      = stim_rb[in_idx];
					in_use_imm = stim_uimm[in_idx];
					in_imm     = stim_imm[in_idx];
				end
			end
		end
		draw_bit(rdy);
		out_ready = rdy;
		#1;
		compare_values("in_ready vs back-pressure", 64'(in_ready), 64'(!(out_valid && !out_ready)));
		// Result refused last cycle must be unchanged
		if (held) begin
			compare_values("held out_valid", 64'(out_valid), 64'd1);
			compare_values("held out_rd", 64'(out_rd), 64'(held_rd));
			compare_values("held out_data", 64'(out_data), 64'(held_data));
		end
		if (out_valid && out_ready) begin
			if (out_idx >= n_ops) begin
				$display("a result appeared after the last expected one");
				$display("test failed");
				$fatal(1, "extra result");
			end
			compare_values($sformatf("out_rd of micro-op %0d", out_idx),
				64'(out_rd), 64'(stim_rd[out_idx]));
			compare_values($sformatf("out_data of micro-op %0d", out_idx),
				64'(out_data), 64'(stim_exp[out_idx]));
			out_idx++;
		end
		held      = out_valid && !out_ready;
		held_rd   = out_rd;
		held_data = out_data;
		in_fire   = in_valid && in_ready;
		if (in_fire) in_idx++;
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_op       = '0;
		in_rd       = '0;
		in_ra       = '0;
		in_rb       = '0;
		in_use_imm  = 1'b0;
		in_imm      = '0;
		out_ready   = 1'b0;
		in_idx      = 0;
		out_idx     = 0;
		in_fire     = 1'b0;
		held        = 1'b0;
		held_rd     = '0;
		held_data   = '0;
		lfsr_state  = 17'd68826;
		loaded      = 1'b0;
		load_stim();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		compare_values("out_valid after reset", 64'(out_valid), 64'd0);
		compare_values("in_ready after reset", 64'(in_ready), 64'd1);
		while (out_idx < n_ops) run_cycle();
		// Pipe must stay empty once all results are out
		repeat (6) begin
			run_cycle();
			compare_values("out_valid after last result", 64'(out_valid), 64'd0);
		end
		if (n_ops > 0) begin
			$display("test passed");
		end else begin
			$display("no micro-ops were run");
			$display("test failed");
		end
		$finish;
	end

	// 40 cycles per micro-op plus reset
	initial begin
		wait (loaded);
		repeat (n_ops * 40 + 8) @(posedge clk);
		$display("timeout, only %0d of %0d results arrived", out_idx, n_ops);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* opx_pipe.f */
hdl/opx_pkg.sv
hdl/opx_regfile.sv
hdl/opx_operand_mux.sv
hdl/opx_pipe_ctrl.sv
hdl/opx_alu.sv
hdl/opx_pipe.sv
tb/opx_pipe_tb.sv

/* Makefile */
SIM_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint clean

# Build, run, then look for the pass line in the log
all:
	verilator --binary --timing --assert -j 0 --top-module opx_pipe_tb \
		-f opx_pipe.f -Mdir $(SIM_DIR) -o opx_pipe_sim
	./$(SIM_DIR)/opx_pipe_sim | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	verilator --lint-only --timing --top-module opx_pipe_tb -f opx_pipe.f

clean:
	rm -rf $(SIM_DIR) $(LOG)

/* tb/opx_stim.txt */
# op rd ra rb use_imm imm expected, all hex, registers start at zero
# op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt; rb unused when use_imm is 1
0 1 f 0 1 12345678 12345678
0 2 0 0 1 00000005 00000005
0 3 1 2 0 00000000 1234567d
1 4 3 1 0 00000000 00000005
2 5 3 0 1 0000ff0f 0000560d
3 6 5 0 1 f0000000 f000560d
4 7 6 1 0 00000000 e2340075
5 8 2 0 1 00000004 00000050
6 9 7 0 1 00000008 00e23400
7 a 7 1 0 00000000 00000001
7 b 1 7 0 00000000 00000000
7 c 7 0 1 ffffffff 00000001
0 0 1 2 0 00000000 1234567d
0 d 0 2 0 00000000 00000005
3 e 0 0 0 00000000 00000000
5 f 1 0 1 00000024 23456780
6 3 f 8 0 00000000 00002345
1 3 3 3 0 00000000 00000000
1 4 3 0 1 00000001 ffffffff
0 4 4 4 0 00000000 fffffffe
4 5 4 6 0 00000000 0fffa9f3
2 6 5 9 0 00000000 00e22000
0 7 6 5 0 00000000 10e1c9f3
7 8 4 0 0 00000000 00000001
1 9 8 7 0 00000000 ef1e360e
6 a 9 0 1 0000001f 00000001
5 b a a 0 00000000 00000002
0 c b d 0 00000000 00000007
